/* common/mipsPkg.sv */
package mipsPkg;

    // Core widths and fixed addresses
    localparam int DATA_WIDTH = 32;
    localparam int REG_COUNT = 32;
    localparam logic [DATA_WIDTH-1:0] RESET_VECTOR = 32'hBFC0_0000;
    localparam logic [DATA_WIDTH-1:0] HALT_ADDRESS = 32'h0000_0000;
    localparam logic [4:0] LINK_REG = 5'd31; // $ra
    localparam logic [4:0] V0_REG = 5'd2;    // $v0
    localparam logic [3:0] BYTE_ENABLE_ALL = 4'b1111;

    // Primary opcodes, kept subset only
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,  // R-type, decoded by funct
        OP_REGIMM  = 6'd1,  // Branch group, decoded by rt
        OP_J       = 6'd2,
        OP_JAL     = 6'd3,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_BLEZ    = 6'd6,
        OP_BGTZ    = 6'd7,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_JALR = 6'd9,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_e;

    // REGIMM selectors live in the rt field
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'd0,
        RI_BGEZ   = 5'd1,
        RI_BLTZAL = 5'd16,
        RI_BGEZAL = 5'd17
    } regimm_e;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2,  // Load write-back
        HALT  = 2'd3
    } cpuState_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
    } iFormat_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [25:0] target; // Word index within 256MB region
    } jFormat_t;

    // Same word seen through all three layouts
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        jFormat_t j;
    } instrWord_u;

    typedef struct packed {
        logic en;
        logic [4:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } regWrite_t;

    typedef struct packed {
        logic taken;
        logic [DATA_WIDTH-1:0] target;
    } branchDecision_t;

endpackage

/* src/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  logic [4:0] rsAddr,
    input  logic [4:0] rtAddr,
    output logic [mipsPkg::DATA_WIDTH-1:0] rsValue,
    output logic [mipsPkg::DATA_WIDTH-1:0] rtValue,
    output logic [mipsPkg::DATA_WIDTH-1:0] v0Value,
    input  mipsPkg::regWrite_t regWrite
);

    logic [mipsPkg::DATA_WIDTH-1:0] regs [mipsPkg::REG_COUNT];

    // Single write port, $zero never written so it reads back zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mipsPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite.en && regWrite.addr != 5'd0) begin
            regs[regWrite.addr] <= regWrite.data;
        end
    end

    // Combinational reads, new value visible next cycle
    assign rsValue = regs[rsAddr];
    assign rtValue = regs[rtAddr];
    assign v0Value = regs[mipsPkg::V0_REG]; // Straight to registerV0

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mipsPkg::instrWord_u instr,
    input  logic [mipsPkg::DATA_WIDTH-1:0] rsValue,
    input  logic [mipsPkg::DATA_WIDTH-1:0] rtValue,
    output mipsPkg::regWrite_t aluWrite,
    output logic [mipsPkg::DATA_WIDTH-1:0] effAddr
);

    logic [mipsPkg::DATA_WIDTH-1:0] signExt;
    logic [mipsPkg::DATA_WIDTH-1:0] zeroExt;

    assign signExt = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign zeroExt = {16'b0, instr.i.imm}; // Logical immediates

    // LW and SW share base plus offset
    assign effAddr = rsValue + signExt;

    always_comb begin
        aluWrite.en = 1'b0;
        aluWrite.addr = instr.i.rt; // I-type target by default
        aluWrite.data = '0;
        case (instr.i.opcode)
            mipsPkg::OP_SPECIAL: begin
                aluWrite.en = 1'b1;
                aluWrite.addr = instr.r.rd;
                case (instr.r.funct)
                    mipsPkg::FN_ADDU: aluWrite.data = rsValue + rtValue;
                    mipsPkg::FN_SUBU: aluWrite.data = rsValue - rtValue;
                    mipsPkg::FN_AND:  aluWrite.data = rsValue & rtValue;
                    mipsPkg::FN_OR:   aluWrite.data = rsValue | rtValue;
                    mipsPkg::FN_XOR:  aluWrite.data = rsValue ^ rtValue;
                    mipsPkg::FN_SLT:  aluWrite.data[0] = $signed(rsValue) < $signed(rtValue);
                    mipsPkg::FN_SLTU: aluWrite.data[0] = rsValue < rtValue;
                    mipsPkg::FN_SLL:  aluWrite.data = rtValue << instr.r.shamt;
                    mipsPkg::FN_SRL:  aluWrite.data = rtValue >> instr.r.shamt;
                    mipsPkg::FN_SRA:  aluWrite.data = $signed(rtValue) >>> instr.r.shamt;
                    // Variable shifts use low five bits of rs
                    mipsPkg::FN_SLLV: aluWrite.data = rtValue << rsValue[4:0];
                    mipsPkg::FN_SRLV: aluWrite.data = rtValue >> rsValue[4:0];
                    mipsPkg::FN_SRAV: aluWrite.data = $signed(rtValue) >>> rsValue[4:0];
                    default: aluWrite.en = 1'b0; // JR, JALR and unknowns
                endcase
            end
            mipsPkg::OP_ADDIU: begin
                aluWrite.en = 1'b1;
                aluWrite.data = rsValue + signExt;
            end
            mipsPkg::OP_SLTI: begin
                aluWrite.en = 1'b1;
                aluWrite.data[0] = $signed(rsValue) < $signed(signExt);
            end
            mipsPkg::OP_SLTIU: begin
                aluWrite.en = 1'b1;
                aluWrite.data[0] = rsValue < signExt; // Sign-extended, compared unsigned
            end
            mipsPkg::OP_ANDI: begin
                aluWrite.en = 1'b1;
                aluWrite.data = rsValue & zeroExt;
            end
            mipsPkg::OP_ORI: begin
                aluWrite.en = 1'b1;
                aluWrite.data = rsValue | zeroExt;
            end
            mipsPkg::OP_XORI: begin
                aluWrite.en = 1'b1;
                aluWrite.data = rsValue ^ zeroExt;
            end
            mipsPkg::OP_LUI: begin
                aluWrite.en = 1'b1;
                aluWrite.data = {instr.i.imm, 16'b0};
            end
            default: aluWrite.en = 1'b0; // Branches, memory, unknown
        endcase
    end

endmodule

/* src/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit (
    input  mipsPkg::instrWord_u instr,
    input  logic [mipsPkg::DATA_WIDTH-1:0] pcPlus4,
    input  logic [mipsPkg::DATA_WIDTH-1:0] rsValue,
    input  logic [mipsPkg::DATA_WIDTH-1:0] rtValue,
    output mipsPkg::branchDecision_t branch,
    output mipsPkg::regWrite_t linkWrite
);

    logic [mipsPkg::DATA_WIDTH-1:0] branchTarget;
    logic [mipsPkg::DATA_WIDTH-1:0] jumpTarget;
    logic rsNeg;
    logic rsZero;

    // Offsets are relative to the delay slot
    assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instr.j.target, 2'b00};
    assign rsNeg = rsValue[mipsPkg::DATA_WIDTH-1];
    assign rsZero = rsValue == '0;

    always_comb begin
        branch.taken = 1'b0;
        branch.target = branchTarget;
        linkWrite.en = 1'b0;
        linkWrite.addr = mipsPkg::LINK_REG;
        linkWrite.data = pcPlus4 + 32'd4; // Return past the delay slot
        case (instr.i.opcode)
            mipsPkg::OP_SPECIAL: begin
                branch.target = rsValue;
                case (instr.r.funct)
                    mipsPkg::FN_JR: branch.taken = 1'b1;
                    mipsPkg::FN_JALR: begin
                        branch.taken = 1'b1;
                        linkWrite.en = 1'b1;
                        linkWrite.addr = instr.r.rd;
                    end
                    default: branch.taken = 1'b0;
                endcase
            end
            mipsPkg::OP_REGIMM: begin
                case (instr.i.rt)
                    mipsPkg::RI_BLTZ: branch.taken = rsNeg;
                    mipsPkg::RI_BGEZ: branch.taken = !rsNeg;
                    mipsPkg::RI_BLTZAL: begin
                        branch.taken = rsNeg;
                        linkWrite.en = 1'b1; // Links even when not taken
                    end
                    mipsPkg::RI_BGEZAL: begin
                        branch.taken = !rsNeg;
                        linkWrite.en = 1'b1;
                    end
                    default: branch.taken = 1'b0;
                endcase
            end
            mipsPkg::OP_J: begin
                branch.taken = 1'b1;
                branch.target = jumpTarget;
            end
            mipsPkg::OP_JAL: begin
                branch.taken = 1'b1;
                branch.target = jumpTarget;
                linkWrite.en = 1'b1;
            end
            mipsPkg::OP_BEQ:  branch.taken = rsValue == rtValue;
            mipsPkg::OP_BNE:  branch.taken = rsValue != rtValue;
            mipsPkg::OP_BLEZ: branch.taken = rsNeg || rsZero;
            mipsPkg::OP_BGTZ: branch.taken = !rsNeg && !rsZero;
            default: branch.taken = 1'b0;
        endcase
    end

endmodule

/* core/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
    input  logic clk,
    input  logic reset,
    output mipsPkg::instrWord_u instr,
    output logic [mipsPkg::DATA_WIDTH-1:0] pcPlus4,
    input  mipsPkg::regWrite_t aluWrite,
    input  mipsPkg::regWrite_t linkWrite,
    input  logic [mipsPkg::DATA_WIDTH-1:0] effAddr,
    input  mipsPkg::branchDecision_t branch,
    input  logic [mipsPkg::DATA_WIDTH-1:0] rtValue,
    output mipsPkg::regWrite_t regWrite,
    output logic active,
    output logic [mipsPkg::DATA_WIDTH-1:0] address,
    output logic read,
    output logic write,
    output logic [mipsPkg::DATA_WIDTH-1:0] writeData,
    output logic [3:0] byteEnable,
    input  logic waitRequest,
    input  logic [mipsPkg::DATA_WIDTH-1:0] readData
);

    mipsPkg::cpuState_e state;
    logic [mipsPkg::DATA_WIDTH-1:0] pc;
    logic [mipsPkg::DATA_WIDTH-1:0] nextPc;
    logic [mipsPkg::DATA_WIDTH-1:0] pendingTarget; // Redirect after the delay slot
    logic inDelaySlot;                             // Current instr sits in a delay slot
    mipsPkg::regWrite_t loadWrite;                 // Captured load for EXEC2
    logic isLoad;
    logic isStore;
    logic atHalt;
    logic retire;

    // Only memory ops matter here, rest is the ALU's and branch unit's job
    assign isLoad = instr.i.opcode == mipsPkg::OP_LW;
    assign isStore = instr.i.opcode == mipsPkg::OP_SW;
    assign atHalt = pc == mipsPkg::HALT_ADDRESS;

    assign pcPlus4 = pc + 32'd4;
    assign nextPc = inDelaySlot ? pendingTarget : pcPlus4;

    // Last cycle of an instruction
    assign retire = (state == mipsPkg::EXEC1 && !isLoad && !(isStore && waitRequest))
                 || (state == mipsPkg::EXEC2);

    assign active = state != mipsPkg::HALT;
    assign byteEnable = mipsPkg::BYTE_ENABLE_ALL; // Word accesses only
    assign writeData = rtValue;

    // Bus drive, held stable by the registers behind it
    always_comb begin
        read = 1'b0;
        write = 1'b0;
        address = pc;
        case (state)
            mipsPkg::FETCH: begin
                read = !atHalt; // No fetch from zero
            end
            mipsPkg::EXEC1: begin
                address = effAddr;
                read = isLoad;
                write = isStore;
            end
            default: begin
                read = 1'b0;
            end
        endcase
    end

    // Write-back select, enable qualified by state
    always_comb begin
        regWrite = aluWrite;
        regWrite.en = 1'b0;
        case (state)
            mipsPkg::EXEC1: begin
                if (linkWrite.en) begin
                    regWrite = linkWrite; // JAL, JALR, linking REGIMM
                end else begin
                    regWrite = aluWrite;  // Enable low for loads and stores
                end
            end
            mipsPkg::EXEC2: begin
                regWrite = loadWrite;
            end
            default: begin
                regWrite.en = 1'b0;
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::FETCH;
            pc <= mipsPkg::RESET_VECTOR;
            inDelaySlot <= 1'b0;
        end else begin
            case (state)
                mipsPkg::FETCH: begin
                    if (atHalt) begin
                        state <= mipsPkg::HALT;
                    end else if (!waitRequest) begin
                        state <= mipsPkg::EXEC1;
                    end
                end
                mipsPkg::EXEC1: begin
                    if (isLoad) begin
                        if (!waitRequest) state <= mipsPkg::EXEC2;
                    end else if (!(isStore && waitRequest)) begin
                        state <= mipsPkg::FETCH;
                    end
                end
                mipsPkg::EXEC2: state <= mipsPkg::FETCH;
                default: state <= mipsPkg::HALT; // Stuck until reset
            endcase
            if (retire) begin
                pc <= nextPc;
                inDelaySlot <= branch.taken; // Next instr becomes the delay slot
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == mipsPkg::FETCH && !atHalt && !waitRequest) begin
            instr <= readData;
        end
        if (state == mipsPkg::EXEC1 && isLoad && !waitRequest) begin
            loadWrite.en <= 1'b1;
            loadWrite.addr <= instr.i.rt;
            loadWrite.data <= readData;
        end
        if (retire && branch.taken) begin
            pendingTarget <= branch.target;
        end
    end

endmodule

/* core/mipsCpuBus.sv */
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [mipsPkg::DATA_WIDTH-1:0] registerV0,
    // Avalon-MM master
    output logic [mipsPkg::DATA_WIDTH-1:0] address,
    output logic read,
    output logic write,
    output logic [mipsPkg::DATA_WIDTH-1:0] writeData,
    output logic [3:0] byteEnable,
    input  logic waitRequest,
    input  logic [mipsPkg::DATA_WIDTH-1:0] readData
);

    mipsPkg::instrWord_u instr;          // Current instruction register
    logic [mipsPkg::DATA_WIDTH-1:0] pcPlus4;  // Delay-slot address
    logic [mipsPkg::DATA_WIDTH-1:0] rsValue;
    logic [mipsPkg::DATA_WIDTH-1:0] rtValue;
    logic [mipsPkg::DATA_WIDTH-1:0] effAddr;
    mipsPkg::regWrite_t aluWrite;
    mipsPkg::regWrite_t linkWrite;
    mipsPkg::regWrite_t regWrite;        // Selected write-back
    mipsPkg::branchDecision_t branch;

    controlFsm u_fsm (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .pcPlus4(pcPlus4),
        .aluWrite(aluWrite),
        .linkWrite(linkWrite),
        .effAddr(effAddr),
        .branch(branch),
        .rtValue(rtValue),
        .regWrite(regWrite),
        .active(active),
        .address(address),
        .read(read),
        .write(write),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .waitRequest(waitRequest),
        .readData(readData)
    );

    regFile u_regFile (
        .clk(clk),
        .reset(reset),
        .rsAddr(instr.r.rs),
        .rtAddr(instr.r.rt),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .v0Value(registerV0),
        .regWrite(regWrite)
    );

    alu u_alu (
        .instr(instr),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .aluWrite(aluWrite),
        .effAddr(effAddr)
    );

    branchUnit u_branch (
        .instr(instr),
        .pcPlus4(pcPlus4),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .branch(branch),
        .linkWrite(linkWrite)
    );

endmodule

/* sim/cpuBus_props.sv */
`timescale 1ns/1ps

module cpuBusProps (
    input logic clk,
    input logic reset,
    input logic active,
    input logic read,
    input logic write,
    input logic [mipsPkg::DATA_WIDTH-1:0] address,
    input logic [mipsPkg::DATA_WIDTH-1:0] writeData,
    input logic [3:0] byteEnable,
    input logic waitRequest
);

    // One direction per transfer
    noReadAndWrite: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    ) else $error("read and write asserted together");

    // Master holds everything while the slave stalls
    holdWhileWaiting: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitRequest |=>
            $stable({read, write, address, writeData, byteEnable})
    ) else $error("master outputs changed during waitRequest");

    quietWhenHalted: assert property (
        @(posedge clk) disable iff (reset) !active |-> !read && !write
    ) else $error("bus access issued while halted");

endmodule

/* sim/mipsCpuBusTb.sv */
`timescale 1ns/1ps

module mipsCpuBusTb;

    localparam int SEED = 47;
    localparam int PROGRAMS = 20;
    localparam int PROG_LEN = 48;          // Random body ahead of the JR tail
    localparam int MAX_INSTR = 50;         // Body plus JR and its delay slot
    localparam int CYCLES_PER_INSTR = 11;  // Load with full wait states, rounded up
    localparam int RESET_CYCLES = 8;
    localparam int HALT_CYCLES = 20;
    localparam int TIMEOUT_CYCLES =
        PROGRAMS * (MAX_INSTR * CYCLES_PER_INSTR + RESET_CYCLES + HALT_CYCLES + 2) + 500;
    localparam logic [15:0] DATA_BASE = 16'h0100;  // Eight scratch words for LW/SW

    localparam logic [5:0] ALU_FUNCTS [13] = '{
        mipsPkg::FN_ADDU, mipsPkg::FN_SUBU, mipsPkg::FN_AND, mipsPkg::FN_OR,
        mipsPkg::FN_XOR, mipsPkg::FN_SLT, mipsPkg::FN_SLTU, mipsPkg::FN_SLL,
        mipsPkg::FN_SRL, mipsPkg::FN_SRA, mipsPkg::FN_SLLV, mipsPkg::FN_SRLV,
        mipsPkg::FN_SRAV
    };
    localparam logic [5:0] IMM_OPS [7] = '{
        mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU, mipsPkg::OP_ANDI,
        mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI
    };

    logic clk;
    logic reset;
    logic active;
    logic read;
    logic write;
    logic waitRequest;
    logic [3:0] byteEnable;
    logic [mipsPkg::DATA_WIDTH-1:0] registerV0;
    logic [mipsPkg::DATA_WIDTH-1:0] address;
    logic [mipsPkg::DATA_WIDTH-1:0] writeData;
    logic [mipsPkg::DATA_WIDTH-1:0] readData;

    logic [31:0] progMem [logic [29:0]];   // DUT side, word addressed
    logic [31:0] modelMem [logic [29:0]];  // Reference model copy
    logic [31:0] storeAddrQ [$];           // Expected stores, in order
    logic [31:0] storeDataQ [$];
    logic [31:0] expectedV0;
    int progIdx = 0;
    int cycleCount;
    int waitLeft;                          // -1 means a fresh access

    mipsCpuBus u_dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .read(read),
        .write(write),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .waitRequest(waitRequest),
        .readData(readData)
    );

    bind mipsCpuBus cpuBusProps u_props (
        .clk(clk),
        .reset(reset),
        .active(active),
        .read(read),
        .write(write),
        .address(address),
        .writeData(writeData),
        .byteEnable(byteEnable),
        .waitRequest(waitRequest)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input logic [mipsPkg::DATA_WIDTH-1:0] expected,
                             input logic [mipsPkg::DATA_WIDTH-1:0] actual);
        if (actual !== expected)
            failRun($sformatf("** Error [%s] expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkBool(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            failRun($sformatf("** Error [%s] expected %b actual %b", name, expected, actual));
    endtask

    // Unwritten words read back a pattern of the full address
    function automatic logic [31:0] memFill(input logic [29:0] wordAddr);
        return {wordAddr, 2'b01} * 32'h9E37_79B1 ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [29:0] wordIndex(input int k);
        return 30'((mipsPkg::RESET_VECTOR >> 2) + k);
    endfunction

    task automatic buildProgram();
        logic [31:0] word;
        logic [15:0] offset;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic prevBranch;
        int kind;
        int target;
        int pick;
        progMem.delete();
        prevBranch = 1'b0;
        for (int k = 0; k < PROG_LEN; k++) begin
            rs = 5'($urandom_range(7));
            rt = 5'($urandom_range(7));
            rd = 5'($urandom_range(7, 1));  // Never $ra, JR $31 must see zero
            kind = int'($urandom_range(10));
            if (kind >= 8 && (prevBranch || k > PROG_LEN - 2))
                kind = 0;                   // Delay slots stay plain
            target = int'($urandom_range(PROG_LEN, k + 2));  // Forward, at most the JR
            offset = 16'(target - k - 1);
            pick = int'($urandom_range(12));
            case (kind)
                0, 1, 2: word = {mipsPkg::OP_SPECIAL, rs, rt, rd, 5'($urandom_range(31)),
                                 ALU_FUNCTS[pick]};
                3, 4: word = {IMM_OPS[pick % 7], rs, rd, 16'($urandom_range(16'hFFFF))};
                5: word = {mipsPkg::OP_LW, 5'd0, rd, DATA_BASE + 16'(4 * $urandom_range(7))};
                6: word = {mipsPkg::OP_SW, 5'd0, rt, DATA_BASE + 16'(4 * $urandom_range(7))};
                7: word = {6'h3F, 26'($urandom)};  // Unassigned opcode, no-op
                8, 9: begin
                    case (pick % 5)
                        0: word = {mipsPkg::OP_BEQ, rs, rt, offset};
                        1: word = {mipsPkg::OP_BNE, rs, rt, offset};
                        2: word = {mipsPkg::OP_BLEZ, rs, 5'd0, offset};
                        3: word = {mipsPkg::OP_BGTZ, rs, 5'd0, offset};
                        default: word = {mipsPkg::OP_REGIMM, rs, 4'd0, rt[0], offset};
                    endcase
                end
                default: word = {mipsPkg::OP_J, 26'((mipsPkg::RESET_VECTOR >> 2) + target)};
            endcase
            prevBranch = kind >= 8;
            progMem[wordIndex(k)] = word;
        end
        // JR $31 back to zero, SLL $0 in its slot
        progMem[wordIndex(PROG_LEN)] = {mipsPkg::OP_SPECIAL, mipsPkg::LINK_REG, 15'd0,
                                        mipsPkg::FN_JR};
        progMem[wordIndex(PROG_LEN + 1)] = 32'h0;
        modelMem = progMem;
    endtask

    // ISA level run of the same program
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] ea;
        logic [31:0] result;
        logic [31:0] target;
        logic [31:0] pending;
        logic [31:0] nextPc;
        logic [4:0] dst;
        logic inSlot;
        logic taken;
        logic wen;
        int steps;
        storeAddrQ.delete();
        storeDataQ.delete();
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        pc = mipsPkg::RESET_VECTOR;
        pending = '0;
        inSlot = 1'b0;
        steps = 0;
        while (pc != mipsPkg::HALT_ADDRESS) begin
            if (steps == MAX_INSTR)
                failRun("reference model ran past the instruction budget");
            word = modelMem.exists(pc[31:2]) ? modelMem[pc[31:2]] : memFill(pc[31:2]);
            rsV = regs[word[25:21]];
            rtV = regs[word[20:16]];
            sImm = {{16{word[15]}}, word[15:0]};
            zImm = {16'd0, word[15:0]};
            ea = rsV + sImm;
            dst = word[20:16];
            wen = 1'b1;
            taken = 1'b0;
            result = '0;
            target = pc + 32'd4 + (sImm << 2);  // Relative to the delay slot
            case (word[31:26])
                mipsPkg::OP_SPECIAL: begin
                    dst = word[15:11];
                    case (word[5:0])
                        mipsPkg::FN_ADDU: result = rsV + rtV;
                        mipsPkg::FN_SUBU: result = rsV - rtV;
                        mipsPkg::FN_AND: result = rsV & rtV;
                        mipsPkg::FN_OR: result = rsV | rtV;
                        mipsPkg::FN_XOR: result = rsV ^ rtV;
                        mipsPkg::FN_SLT: result = {31'd0, $signed(rsV) < $signed(rtV)};
                        mipsPkg::FN_SLTU: result = {31'd0, rsV < rtV};
                        mipsPkg::FN_SLL: result = rtV << word[10:6];
                        mipsPkg::FN_SRL: result = rtV >> word[10:6];
                        mipsPkg::FN_SRA: result = $signed(rtV) >>> word[10:6];
                        mipsPkg::FN_SLLV: result = rtV << rsV[4:0];
                        mipsPkg::FN_SRLV: result = rtV >> rsV[4:0];
                        mipsPkg::FN_SRAV: result = $signed(rtV) >>> rsV[4:0];
                        mipsPkg::FN_JR: begin
                            wen = 1'b0;
                            taken = 1'b1;
                            target = rsV;
                        end
                        default: wen = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: result = rsV + sImm;
                mipsPkg::OP_SLTI: result = {31'd0, $signed(rsV) < $signed(sImm)};
                mipsPkg::OP_SLTIU: result = {31'd0, rsV < sImm};
                mipsPkg::OP_ANDI: result = rsV & zImm;
                mipsPkg::OP_ORI: result = rsV | zImm;
                mipsPkg::OP_XORI: result = rsV ^ zImm;
                mipsPkg::OP_LUI: result = {word[15:0], 16'd0};
                mipsPkg::OP_LW: result = modelMem.exists(ea[31:2]) ? modelMem[ea[31:2]]
                                                                   : memFill(ea[31:2]);
                mipsPkg::OP_SW: begin
                    wen = 1'b0;
                    storeAddrQ.push_back(ea);
                    storeDataQ.push_back(rtV);
                    modelMem[ea[31:2]] = rtV;
                end
                default: begin
                    wen = 1'b0;
                    case (word[31:26])
                        mipsPkg::OP_BEQ: taken = rsV == rtV;
                        mipsPkg::OP_BNE: taken = rsV != rtV;
                        mipsPkg::OP_BLEZ: taken = $signed(rsV) <= 0;
                        mipsPkg::OP_BGTZ: taken = $signed(rsV) > 0;
                        mipsPkg::OP_REGIMM: taken = word[16] ? !rsV[31] : rsV[31];
                        mipsPkg::OP_J: begin
                            taken = 1'b1;
                            target = {pc[31:28], word[25:0], 2'b00};  // Slot shares region
                        end
                        default: taken = 1'b0;
                    endcase
                end
            endcase
            if (wen && dst != 5'd0)
                regs[dst] = result;
            nextPc = inSlot ? pending : pc + 32'd4;
            inSlot = taken;
            if (taken)
                pending = target;
            pc = nextPc;
            steps++;
        end
        expectedV0 = regs[mipsPkg::V0_REG];
    endtask

    task automatic acceptStore();
        string tag;
        tag = $sformatf("program %0d store at %h", progIdx, address);
        if (storeAddrQ.size() == 0)
            failRun($sformatf("%s was not expected by the reference model", tag));
        checkWord({tag, " address"}, storeAddrQ.pop_front(), address);
        checkWord({tag, " data"}, storeDataQ.pop_front(), writeData);
        checkWord({tag, " byte enable"}, 32'(mipsPkg::BYTE_ENABLE_ALL), 32'(byteEnable));
        progMem[address[31:2]] = writeData;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic checkHalt();
        string tag;
        tag = $sformatf("program %0d", progIdx);
        @(negedge clk);
        while (active !== 1'b0)
            @(negedge clk);
        checkWord({tag, " halt address"}, mipsPkg::HALT_ADDRESS, address);
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            checkBool({tag, " active in halt"}, 1'b0, active);
            checkBool({tag, " read in halt"}, 1'b0, read);
            checkBool({tag, " write in halt"}, 1'b0, write);
        end
        checkWord({tag, " registerV0"}, expectedV0, registerV0);
        checkWord({tag, " stores missing"}, 32'd0, 32'(storeAddrQ.size()));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Avalon slave with 0 to 3 wait cycles per access
    initial begin
        waitRequest = 1'b0;
        readData = '0;
        waitLeft = -1;
        forever begin
            @(posedge clk);
            #1;
            if (read || write) begin
                if (waitLeft < 0)
                    waitLeft = int'($urandom_range(3));
                if (waitLeft > 0) begin
                    waitRequest = 1'b1;
                    waitLeft--;
                end else begin
                    waitRequest = 1'b0;    // Completes at the coming edge
                    waitLeft = -1;
                    if (read)
                        readData = progMem.exists(address[31:2]) ? progMem[address[31:2]]
                                                                 : memFill(address[31:2]);
                    else
                        acceptStore();
                end
            end else begin
                waitRequest = 1'b0;
                waitLeft = -1;
            end
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > TIMEOUT_CYCLES)
                failRun($sformatf("timeout, core did not halt within %0d cycles",
                                  TIMEOUT_CYCLES));
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        for (int p = 0; p < PROGRAMS; p++) begin
            progIdx = p;
            buildProgram();
            runModel();
            applyReset();
            checkHalt();                  // v0, stores and quiet bus
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
common/mipsPkg.sv
src/regFile.sv
src/alu.sv
src/branchUnit.sv
core/controlFsm.sv
core/mipsCpuBus.sv
sim/cpuBus_props.sv
sim/mipsCpuBusTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mipsCpuBusTb -f filelist.f -o mipsCpuBusSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mipsCpuBusSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
